// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    //////////////////////////////
    // timing

    localparam int CLKS_PER_TICK = 4;   // 50 MHz clocks per 16x tick
    localparam int OVERSAMPLE    = 16;  // ticks per bit
    localparam int HALF_BIT      = 8;   // start edge to mid start bit
    localparam int DATA_BITS     = 8;   // no parity, one stop

    //////////////////////////////
    // receive buffer

    localparam int FIFO_DEPTH    = 8;
    localparam int RTS_LEVEL     = 6;   // rts high at this fill and above

    //////////////////////////////
    // types

    typedef logic [DATA_BITS-1:0] byte_t;     // one data byte
    typedef logic [3:0]           tick_cnt_t; // ticks within a bit
    typedef logic [2:0]           bit_cnt_t;  // data bit index
    typedef logic [3:0]           fifo_cnt_t; // 0 .. FIFO_DEPTH

    typedef enum logic [1:0] {
        RX_IDLE,   // line high, waiting for falling edge
        RX_START,  // counting to mid start bit
        RX_DATA,   // sampling data bits
        RX_STOP    // waiting for mid stop bit
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

// ==== logic/uart_baud_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// 16x oversampling tick shared by rx and tx
module uart_baud_gen (
    input  wire  clk,
    input  wire  rst,
    output logic os_tick   // one clock wide
);

    // divider wide enough for CLKS_PER_TICK - 1
    logic [$clog2(uart_pkg::CLKS_PER_TICK)-1:0] div_cnt;
    logic                                       div_wrap;

    // last clock of a tick period
    assign div_wrap = (int'(div_cnt) == uart_pkg::CLKS_PER_TICK - 1);

    //////////////////////////////
    // free-running divider

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            os_tick <= 1'b0;
        end else begin
            if (div_wrap) begin
                div_cnt <= '0;   // restart period
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // registered so tick is glitch free
            os_tick <= div_wrap;
        end
    end

    // both directions see the same tick
    // so their bit periods agree exactly
    // first tick comes CLKS_PER_TICK clocks after reset

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  wire             clk,
    input  wire             rst,
    input  wire             rxd,        // async serial line
    input  wire             os_tick,    // 16x bit rate
    output uart_pkg::byte_t rx_byte,    // held until next frame
    output logic            rx_wr,      // good frame strobe
    output logic            frame_err   // stop bit low strobe
);

    logic                rxd_meta;   // first sync stage
    logic                rxd_sync;   // safe to use
    uart_pkg::rx_state_t state;
    uart_pkg::tick_cnt_t tick_cnt;   // ticks into current bit
    uart_pkg::bit_cnt_t  bit_idx;    // data bit being sampled
    uart_pkg::byte_t     shift_reg;
    logic                tick_half;  // mid start bit reached
    logic                tick_last;  // full bit elapsed

    assign tick_half = os_tick &&
                       (tick_cnt == uart_pkg::tick_cnt_t'(uart_pkg::HALF_BIT - 1));
    assign tick_last = os_tick &&
                       (tick_cnt == uart_pkg::tick_cnt_t'(uart_pkg::OVERSAMPLE - 1));

    //////////////////////////////
    // input synchronizer

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;   // idle line is high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    //////////////////////////////
    // frame state machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= uart_pkg::RX_IDLE;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            rx_wr     <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // strobes default low
            rx_wr     <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= uart_pkg::RX_START;   // possible start edge
                    end
                end
                uart_pkg::RX_START: begin
                    if (tick_half) begin
                        tick_cnt <= '0;   // later samples land mid-bit
                        bit_idx  <= '0;
                        if (rxd_sync) begin
                            // high again, just a glitch
                            state <= uart_pkg::RX_IDLE;
                        end else begin
                            state <= uart_pkg::RX_DATA;
                        end
                    end else if (os_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (tick_last) begin
                        tick_cnt <= '0;
                        if (bit_idx == uart_pkg::bit_cnt_t'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else if (os_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (tick_last) begin
                        // byte released only once stop bit is judged
                        rx_wr     <= rxd_sync;
                        frame_err <= !rxd_sync;
                        state     <= uart_pkg::RX_IDLE;
                    end else if (os_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // data shifter

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && tick_last) begin
            shift_reg <= {rxd_sync, shift_reg[uart_pkg::DATA_BITS-1:1]};
        end
    end

    // stable through the stop bit and the rx_wr strobe
    assign rx_byte = shift_reg;

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  wire             clk,
    input  wire             rst,
    input  wire             [uart_pkg::DATA_BITS-1:0] tx_data,
    input  wire             tx_start,   // ignored while busy
    input  wire             os_tick,
    output logic            txd,        // registered serial out
    output logic            tx_busy
);

    uart_pkg::tx_state_t state;
    uart_pkg::tick_cnt_t tick_cnt;
    uart_pkg::bit_cnt_t  bit_idx;
    uart_pkg::byte_t     shift_reg;   // bit 0 is next to send
    logic                accept;
    logic                tick_last;

    assign accept    = (state == uart_pkg::TX_IDLE) && tx_start;
    assign tick_last = os_tick &&
                       (tick_cnt == uart_pkg::tick_cnt_t'(uart_pkg::OVERSAMPLE - 1));

    //////////////////////////////
    // shift-out state machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            txd      <= 1'b1;   // line idles high
            tx_busy  <= 1'b0;
        end else begin
            if (os_tick) begin
                tick_cnt <= tick_cnt + 1'b1;   // wraps after 16
            end
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (accept) begin
                        state    <= uart_pkg::TX_START;
                        tick_cnt <= '0;   // counted from next tick
                        txd      <= 1'b0; // start bit
                        tx_busy  <= 1'b1;
                    end
                end
                uart_pkg::TX_START: begin
                    if (tick_last) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        txd     <= shift_reg[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (tick_last) begin
                        if (bit_idx == uart_pkg::bit_cnt_t'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::TX_STOP;
                            txd   <= 1'b1;   // stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shift_reg[1];   // next bit before the shift
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (tick_last) begin
                        state   <= uart_pkg::TX_IDLE;
                        tx_busy <= 1'b0;   // frame done
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // byte latch

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= tx_data;
        end else if (state == uart_pkg::TX_DATA && tick_last) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_rx_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

// show-ahead receive buffer
module uart_rx_fifo (
    input  wire             clk,
    input  wire             rst,
    input  wire             wr,         // from rx_wr
    input  wire             [uart_pkg::DATA_BITS-1:0] wr_data,
    input  wire             rd_en,      // pop head
    output uart_pkg::byte_t rd_data,    // head, valid with rd_valid
    output logic            rd_valid,
    output logic            overrun,    // write dropped, fifo full
    output logic            rts         // active low, low means room
);

    // depth is a power of two so pointers wrap by themselves
    uart_pkg::byte_t                          mem [uart_pkg::FIFO_DEPTH];
    logic [$clog2(uart_pkg::FIFO_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(uart_pkg::FIFO_DEPTH)-1:0]  rd_ptr;
    uart_pkg::fifo_cnt_t                      fill_cnt;
    uart_pkg::fifo_cnt_t                      cnt_next;
    logic                                     full;
    logic                                     empty;
    logic                                     do_wr;
    logic                                     do_rd;

    assign full  = (fill_cnt == uart_pkg::fifo_cnt_t'(uart_pkg::FIFO_DEPTH));
    assign empty = (fill_cnt == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd_en && !empty;   // pop on empty ignored

    always_comb begin
        case ({do_wr, do_rd})
            2'b10:   cnt_next = fill_cnt + 1'b1;
            2'b01:   cnt_next = fill_cnt - 1'b1;
            default: cnt_next = fill_cnt;   // none, or both at once
        endcase
    end

    //////////////////////////////
    // pointers, count, rts

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
            rts      <= 1'b0;   // ready after reset
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            fill_cnt <= cnt_next;
            // from the next count so rts tracks fill_cnt exactly
            rts <= (cnt_next >= uart_pkg::fifo_cnt_t'(uart_pkg::RTS_LEVEL));
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_data  = mem[rd_ptr];   // head, no read latency
    assign rd_valid = !empty;
    assign overrun  = wr && full;    // same cycle as the dropped byte

endmodule

`default_nettype wire

// ==== logic/uart_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_core (
    input  wire  clk,
    input  wire  rst,
    input  wire  rxd,        // serial in
    input  wire  [uart_pkg::DATA_BITS-1:0] tx_data,
    input  wire  tx_start,   // one byte per strobe
    input  wire  rd_en,      // pop receive head
    output wire  txd,        // serial out
    output wire  tx_busy,
    output wire  [uart_pkg::DATA_BITS-1:0] rd_data,
    output wire  rd_valid,
    output wire  frame_err,
    output wire  overrun,
    output wire  rts         // active low request to send
);

    logic            os_tick;   // shared 16x tick
    uart_pkg::byte_t rx_byte;   // rx to fifo
    logic            rx_wr;

    //////////////////////////////
    // tick source

    uart_baud_gen i_baud_gen (
        .clk     (clk),
        .rst     (rst),
        .os_tick (os_tick)
    );

    //////////////////////////////
    // receive path

    uart_rx i_rx (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .os_tick   (os_tick),
        .rx_byte   (rx_byte),
        .rx_wr     (rx_wr),
        .frame_err (frame_err)
    );

    // fifo space replaces any rx ready input
    uart_rx_fifo i_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr       (rx_wr),
        .wr_data  (rx_byte),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .overrun  (overrun),
        .rts      (rts)
    );

    //////////////////////////////
    // transmit path

    uart_tx i_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .os_tick  (os_tick),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

`default_nettype wire

// ==== bench/uart_core_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

// protocol rules on the core, bound in below
module uart_core_assert (
    input wire                      clk,
    input wire                      rst,
    input wire                      txd,
    input wire                      tx_busy,
    input wire                      rx_wr,       // internal rx to fifo strobe
    input wire                      frame_err,
    input wire uart_pkg::fifo_cnt_t fill_cnt,    // fifo occupancy
    input wire                      overrun
);

    logic fifo_full;
    int   fail_cnt = 0;   // assertion failures so far

    assign fifo_full = (fill_cnt == uart_pkg::fifo_cnt_t'(uart_pkg::FIFO_DEPTH));

    // line idles high between frames
    txd_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> txd)
        else begin
            fail_cnt++;
            $error("txd low while transmitter idle");
        end

    // one verdict per frame
    rx_verdict_once: assert property (@(posedge clk) disable iff (rst) !(rx_wr && frame_err))
        else begin
            fail_cnt++;
            $error("rx_wr and frame_err high together");
        end

    fill_in_range: assert property (@(posedge clk) disable iff (rst)
        fill_cnt <= uart_pkg::fifo_cnt_t'(uart_pkg::FIFO_DEPTH))
        else begin
            fail_cnt++;
            $error("fifo fill count above depth");
        end

    // dropped byte only when no room
    overrun_when_full: assert property (@(posedge clk) disable iff (rst) overrun |-> fifo_full)
        else begin
            fail_cnt++;
            $error("overrun while fifo not full");
        end

endmodule

bind uart_core uart_core_assert i_assert (
    .clk       (clk),
    .rst       (rst),
    .txd       (txd),
    .tx_busy   (tx_busy),
    .rx_wr     (rx_wr),
    .frame_err (frame_err),
    .fill_cnt  (i_fifo.fill_cnt),
    .overrun   (overrun)
);

`default_nettype wire

// ==== bench/uart_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_core_tb;

    localparam int BIT_CLKS    = uart_pkg::CLKS_PER_TICK * uart_pkg::OVERSAMPLE;  // 64
    localparam int TBL_LEN     = 16;
    localparam int RAND_LEN    = 12;
    localparam int CYCLE_LIMIT = (TBL_LEN + RAND_LEN) * 12 * BIT_CLKS;

    // entry modes
    localparam logic [2:0] M_LOOP   = 3'd0;   // loopback then read back at once
    localparam logic [2:0] M_BUSY   = 3'd1;   // loopback plus a strobe while busy
    localparam logic [2:0] M_BAD    = 3'd2;   // bit-banged with stop bit low
    localparam logic [2:0] M_GLITCH = 3'd3;   // short low pulse only
    localparam logic [2:0] M_BURST  = 3'd4;   // loopback without reading

    typedef struct packed {
        uart_pkg::byte_t data;
        logic [2:0]      mode;
        logic            exp_fe;    // frame_err pulse expected
        logic            exp_ov;    // overrun pulse expected
        logic            exp_rts;   // rts level after the frame
        logic            drain;     // read everything back afterwards
    } entry_t;

    logic            clk = 1'b0;
    logic            rst;
    logic            rxd;
    uart_pkg::byte_t tx_data;
    logic            tx_start;
    logic            rd_en;
    logic            txd;
    logic            tx_busy;
    uart_pkg::byte_t rd_data;
    logic            rd_valid;
    logic            frame_err;
    logic            overrun;
    logic            rts;

    logic            loop_sel;   // 1 = rxd from txd
    logic            bb_line;    // bit-banged serial source
    entry_t          tbl [TBL_LEN];
    uart_pkg::byte_t model_q [$];   // expected fifo contents
    logic [31:0]     rng;
    int              fe_seen = 0;
    int              ov_seen = 0;
    int              err_cnt = 0;
    int              cycle_cnt = 0;

    assign rxd = loop_sel ? txd : bb_line;

    always #10 clk = ~clk;   // 50 MHz

    uart_core i_uart_core (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .rd_en     (rd_en),
        .txd       (txd),
        .tx_busy   (tx_busy),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .frame_err (frame_err),
        .overrun   (overrun),
        .rts       (rts)
    );

    //////////////////////////////
    // pulse counters and watchdog

    always @(posedge clk) begin
        if (rst) begin
            fe_seen <= 0;
            ov_seen <= 0;
        end else begin
            if (frame_err) fe_seen <= fe_seen + 1;
            if (overrun) ov_seen <= ov_seen + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $fatal(1, "simulation stopped by watchdog");
        end
    end

    //////////////////////////////
    // helpers

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "first error, run stopped");
        end
    endtask

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic entry_t make_entry(input uart_pkg::byte_t d, input logic [2:0] m,
                                          input logic fe, input logic ov,
                                          input logic r, input logic dr);
        entry_t e;
        e.data    = d;
        e.mode    = m;
        e.exp_fe  = fe;
        e.exp_ov  = ov;
        e.exp_rts = r;
        e.drain   = dr;
        return e;
    endfunction

    task automatic load_table;
        tbl[0]  = make_entry(8'h55, M_LOOP,   0, 0, 0, 1);
        tbl[1]  = make_entry(8'hA3, M_BUSY,   0, 0, 0, 1);   // extra strobe ignored
        tbl[2]  = make_entry(8'h00, M_LOOP,   0, 0, 0, 1);
        tbl[3]  = make_entry(8'hFF, M_LOOP,   0, 0, 0, 1);
        tbl[4]  = make_entry(8'h3C, M_BAD,    1, 0, 0, 0);
        tbl[5]  = make_entry(8'h00, M_GLITCH, 0, 0, 0, 0);
        tbl[6]  = make_entry(8'h81, M_LOOP,   0, 0, 0, 1);   // recovers after errors
        tbl[7]  = make_entry(8'h11, M_BURST,  0, 0, 0, 0);
        tbl[8]  = make_entry(8'h22, M_BURST,  0, 0, 0, 0);
        tbl[9]  = make_entry(8'h33, M_BURST,  0, 0, 0, 0);
        tbl[10] = make_entry(8'h44, M_BURST,  0, 0, 0, 0);
        tbl[11] = make_entry(8'h5A, M_BURST,  0, 0, 0, 0);
        tbl[12] = make_entry(8'h66, M_BURST,  0, 0, 1, 0);   // six held, rts up
        tbl[13] = make_entry(8'h77, M_BURST,  0, 0, 1, 0);
        tbl[14] = make_entry(8'h88, M_BURST,  0, 0, 1, 0);   // full
        tbl[15] = make_entry(8'h99, M_BURST,  0, 1, 1, 1);   // ninth byte dropped
    endtask

    // hold the bit-banged line for a number of clocks
    task automatic drive_level(input logic val, input int clks);
        bb_line <= val;
        repeat (clks) @(posedge clk);
    endtask

    task automatic bang_frame(input uart_pkg::byte_t data, input logic bad_stop);
        @(posedge clk);
        loop_sel <= 1'b0;
        drive_level(1'b0, BIT_CLKS);   // start
        for (int b = 0; b < uart_pkg::DATA_BITS; b++) begin
            drive_level(data[b], BIT_CLKS);   // lsb first
        end
        if (bad_stop) begin
            drive_level(1'b0, 48);   // low past mid-bit, then back high
        end
        drive_level(1'b1, 2 * BIT_CLKS);
        loop_sel <= 1'b1;
    endtask

    task automatic bang_glitch;
        @(posedge clk);
        loop_sel <= 1'b0;
        drive_level(1'b0, 20);   // well under half a bit
        drive_level(1'b1, 3 * BIT_CLKS);
        loop_sel <= 1'b1;
    endtask

    // one frame through txd, optionally popping one held byte meanwhile
    task automatic send_tx(input uart_pkg::byte_t data, input logic busy_strobe,
                           input logic read_during);
        int   n;
        logic popped;
        n      = 0;
        popped = 1'b0;
        @(posedge clk);
        tx_data  <= data;
        tx_start <= 1'b1;
        @(posedge clk);
        tx_start <= 1'b0;   // accepted at this edge
        @(posedge clk);
        check("tx_busy", tx_busy, 1'b1);
        check("txd", txd, 1'b0);   // start bit
        while (tx_busy) begin
            tx_start <= busy_strobe && (n == 100);
            if (n == 100) tx_data <= ~data;
            if (read_during && !popped && rd_valid && model_q.size() > 0) begin
                check("rd_data", rd_data, model_q[0]);
                void'(model_q.pop_front());
                rd_en  <= 1'b1;
                popped = 1'b1;
            end else begin
                rd_en <= 1'b0;
            end
            n++;
            @(posedge clk);
        end
        rd_en    <= 1'b0;
        tx_start <= 1'b0;
    endtask

    task automatic drain_fifo;
        while (model_q.size() > 0) begin
            @(posedge clk);
            while (!rd_valid) @(posedge clk);
            check("rd_data", rd_data, model_q[0]);
            void'(model_q.pop_front());
            rd_en <= 1'b1;
            @(posedge clk);
            rd_en <= 1'b0;
        end
        @(posedge clk);
        check("rd_valid", rd_valid, 1'b0);   // nothing extra held
        check("rts", rts, 1'b0);
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        int              fe_before;
        int              ov_before;
        uart_pkg::byte_t rb;
        rst      = 1'b1;
        tx_data  = '0;
        tx_start = 1'b0;
        rd_en    = 1'b0;
        loop_sel = 1'b1;
        bb_line  = 1'b1;
        rng      = 32'd28924;
        load_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check("txd", txd, 1'b1);
        check("tx_busy", tx_busy, 1'b0);
        check("rd_valid", rd_valid, 1'b0);
        check("rts", rts, 1'b0);
        check("frame_err", frame_err, 1'b0);
        check("overrun", overrun, 1'b0);

        for (int i = 0; i < TBL_LEN; i++) begin
            fe_before = fe_seen;
            ov_before = ov_seen;
            case (tbl[i].mode)
                M_BAD:    bang_frame(tbl[i].data, 1'b1);
                M_GLITCH: bang_glitch();
                default: begin
                    send_tx(tbl[i].data, tbl[i].mode == M_BUSY, 1'b0);
                    if (model_q.size() < uart_pkg::FIFO_DEPTH) begin
                        model_q.push_back(tbl[i].data);
                    end
                end
            endcase
            @(posedge clk);
            check("frame_err pulses", fe_seen - fe_before, tbl[i].exp_fe);
            check("overrun pulses", ov_seen - ov_before, tbl[i].exp_ov);
            check("rts", rts, tbl[i].exp_rts);
            check("rd_valid", rd_valid, model_q.size() != 0);
            if (tbl[i].drain) drain_fifo();
        end

        // random bytes read back while the next frame is on the line
        for (int r = 0; r < RAND_LEN; r++) begin
            rng = next_rand(rng);
            rb  = rng[7:0];
            send_tx(rb, 1'b0, 1'b1);
            model_q.push_back(rb);
            @(posedge clk);
            check("rts", rts, model_q.size() >= uart_pkg::RTS_LEVEL);
            check("rd_valid", rd_valid, 1'b1);
        end
        drain_fifo();

        if (err_cnt == 0 && i_uart_core.i_assert.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_rx_fifo.sv
logic/uart_core.sv
bench/uart_core_assert.sv
bench/uart_core_tb.sv

// ==== Bender.yml ====
package:
  name: uart_core

sources:
  # rtl, package first
  - logic/uart_pkg.sv
  - logic/uart_baud_gen.sv
  - logic/uart_rx.sv
  - logic/uart_tx.sv
  - logic/uart_rx_fifo.sv
  - logic/uart_core.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/uart_core_assert.sv
      - bench/uart_core_tb.sv
